/* sdmacPkg.sv */
// Shared register map, timing constants, state codes and bus types, imported by every SDMAC block
`default_nettype none

package sdmacPkg;

    // Register offsets on address bits 6:2
    localparam logic [4:0] REG_CNTR  = 5'h02;
    localparam logic [4:0] REG_ACR   = 5'h03;
    localparam logic [4:0] REG_FLUSH = 5'h05;
    localparam logic [4:0] REG_CINT  = 5'h06;
    localparam logic [4:0] REG_ISTR  = 5'h07;

    // CNTR bits
    localparam int CNTR_INTENA = 2;
    localparam int CNTR_DMAENA = 3;

    // ISTR bits
    localparam int ISTR_FEMPTY    = 0;
    localparam int ISTR_FFULL     = 1;
    localparam int ISTR_INTPEND   = 4;
    localparam int ISTR_INTA      = 6;
    localparam int ISTR_FLUSHDONE = 7;

    localparam int FIFO_DEPTH = 8;  // Longwords
    localparam int FIFO_PTR_W = 3;
    localparam int FIFO_CNT_W = FIFO_PTR_W + 1;

    localparam int IOR_CYCLES = 2;  // Read strobe length in clocks

    // Peripheral port sequencer
    localparam logic [1:0] XFER_IDLE    = 2'd0;
    localparam logic [1:0] XFER_STROBE  = 2'd1;
    localparam logic [1:0] XFER_RECOVER = 2'd2;

    // Bus master sequencer
    localparam logic [2:0] BM_IDLE   = 3'd0;
    localparam logic [2:0] BM_REQ    = 3'd1;
    localparam logic [2:0] BM_OWN    = 3'd2;
    localparam logic [2:0] BM_STROBE = 3'd3;
    localparam logic [2:0] BM_END    = 3'd4;

    typedef struct packed {
        logic        strobe;
        logic        write;
        logic [4:0]  addr;
        logic [31:0] wdata;
    } regAccess_s;

    typedef struct packed {
        logic        dmaEna;    // Level
        logic        flushReq;  // One clock pulse
        logic [31:0] acr;
        logic        acrLoad;   // One clock pulse
    } dmaCtrl_s;

    typedef struct packed {
        logic empty;
        logic full;
        logic wordReady;
        logic leftover;
        logic flushDone;  // One clock pulse
    } fifoStat_s;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } busCycle_s;

    // Lane 3 holds the first byte from the SCSI port
    typedef union packed {
        logic [3:0][7:0] lane;
        logic [31:0]     lword;
    } fifoWord_u;

endpackage

`default_nettype wire

/* regDecode.sv */
// CPU register port of the SDMAC: control and address registers, status read-back and interrupt
`default_nettype none

module regDecode import sdmacPkg::*; (
    input  logic       nSCLK,
    input  logic       nAS_,
    input  regAccess_s regAcc_i,
    input  fifoStat_s  fifoStat_i,
    input  logic       intA_i,
    output dmaCtrl_s   ctrl_o,
    output logic [31:0] regRdata_o,
    output logic       intO_
);

    logic        wrStb;
    logic        rdStb;
    logic        dmaEna;
    logic        intEna;
    logic        flushSeen;  // Flush finished, waiting for CINT
    logic        flushReq;
    logic        acrLoad;
    logic [31:0] acr;
    logic        intPend;
    logic [31:0] cntrWord;
    logic [31:0] istrWord;
    logic [31:0] rdMux;

    assign wrStb = regAcc_i.strobe & regAcc_i.write;
    assign rdStb = regAcc_i.strobe & ~regAcc_i.write;

    // SCSI chip interrupt or finished flush, only when enabled
    assign intPend = intEna & (intA_i | flushSeen);
    assign intO_   = ~intPend;

    always_comb begin
        cntrWord = '0;
        cntrWord[CNTR_DMAENA] = dmaEna;
        cntrWord[CNTR_INTENA] = intEna;

        istrWord = '0;
        istrWord[ISTR_FEMPTY]    = fifoStat_i.empty;
        istrWord[ISTR_FFULL]     = fifoStat_i.full;
        istrWord[ISTR_INTPEND]   = intPend;
        istrWord[ISTR_INTA]      = intA_i;
        istrWord[ISTR_FLUSHDONE] = flushSeen;

        case (regAcc_i.addr)
            REG_CNTR: rdMux = cntrWord;
            REG_ACR:  rdMux = acr;
            REG_ISTR: rdMux = istrWord;
            default:  rdMux = '0;  // Strobe-only registers read as zero
        endcase
    end

    always_ff @(posedge nSCLK or negedge nAS_) begin
        if (!nAS_) begin
            dmaEna     <= 1'b0;
            intEna     <= 1'b0;
            flushSeen  <= 1'b0;
            flushReq   <= 1'b0;
            acrLoad    <= 1'b0;
            acr        <= '0;
            regRdata_o <= '0;
        end else begin
            flushReq <= wrStb && (regAcc_i.addr == REG_FLUSH);
            acrLoad  <= wrStb && (regAcc_i.addr == REG_ACR);

            if (wrStb && (regAcc_i.addr == REG_CNTR)) begin
                dmaEna <= regAcc_i.wdata[CNTR_DMAENA];
                intEna <= regAcc_i.wdata[CNTR_INTENA];
            end

            if (wrStb && (regAcc_i.addr == REG_ACR))
                acr <= {regAcc_i.wdata[31:2], 2'b00};  // Longword aligned

            if (wrStb && (regAcc_i.addr == REG_CINT))
                flushSeen <= 1'b0;
            else if (fifoStat_i.flushDone)
                flushSeen <= 1'b1;

            if (rdStb)
                regRdata_o <= rdMux;  // Held until the next read
        end
    end

    assign ctrl_o = '{dmaEna: dmaEna, flushReq: flushReq, acr: acr, acrLoad: acrLoad};

endmodule

`default_nettype wire

/* scsiXfer.sv */
// Peripheral port sequencer: answers SCSI DREQ with DACK and IOR and hands each byte to the FIFO
`default_nettype none

module scsiXfer import sdmacPkg::*; (
    input  logic       nSCLK,
    input  logic       nAS_,
    input  dmaCtrl_s   ctrl_i,
    input  logic       fifoFull_i,
    input  logic       dreqI_,
    input  logic [7:0] pdI,
    output logic       dackO_,
    output logic       iorO_,
    output logic       byteStb_o,
    output logic [7:0] byte_o
);

    logic [1:0] state;
    logic [1:0] strobeCnt;
    logic       startByte;
    logic       lastStrobe;

    // No new byte while the FIFO is full, DREQ just stays low
    assign startByte = (state == XFER_IDLE) && !dreqI_ && ctrl_i.dmaEna && !fifoFull_i;

    assign lastStrobe = (state == XFER_STROBE) && (strobeCnt == 2'(IOR_CYCLES - 1));

    // DACK and IOR share one timing
    assign dackO_ = (state != XFER_STROBE);
    assign iorO_  = (state != XFER_STROBE);

    always_ff @(posedge nSCLK or negedge nAS_) begin
        if (!nAS_) begin
            state     <= XFER_IDLE;
            strobeCnt <= '0;
            byteStb_o <= 1'b0;
        end else begin
            byteStb_o <= lastStrobe;

            case (state)
                XFER_IDLE: begin
                    strobeCnt <= '0;
                    if (startByte)
                        state <= XFER_STROBE;
                end

                XFER_STROBE: begin
                    strobeCnt <= strobeCnt + 2'd1;
                    if (lastStrobe)
                        state <= XFER_RECOVER;
                end

                // One idle clock before DREQ is looked at again
                XFER_RECOVER: state <= XFER_IDLE;

                default: state <= XFER_IDLE;
            endcase
        end
    end

    // Port byte sampled on the last strobe clock
    always_ff @(posedge nSCLK) begin
        if (lastStrobe)
            byte_o <= pdI;
    end

endmodule

`default_nettype wire

/* byteFifo.sv */
// Longword FIFO that packs SCSI bytes first-byte-high and pads a partial word on flush
`default_nettype none

module byteFifo import sdmacPkg::*; (
    input  logic       nSCLK,
    input  logic       nAS_,
    input  dmaCtrl_s   ctrl_i,
    input  logic       byteStb_i,
    input  logic [7:0] byte_i,
    input  logic       pop_i,
    output fifoWord_u  head_o,
    output fifoStat_s  stat_o
);

    fifoWord_u mem [FIFO_DEPTH];

    fifoWord_u packWord;  // Word being assembled, unused lanes kept zero
    fifoWord_u pushWord;
    logic [1:0] bytePtr;  // Lanes already filled
    logic [FIFO_PTR_W-1:0] wrPtr;
    logic [FIFO_PTR_W-1:0] rdPtr;
    logic [FIFO_CNT_W-1:0] count;
    logic full;
    logic fullPush;
    logic flushPush;
    logic push;
    logic pop;
    logic flushPend;
    logic drained;
    logic flushDone;

    assign full = (count == FIFO_CNT_W'(FIFO_DEPTH));

    always_comb begin
        pushWord = packWord;
        if (byteStb_i)
            pushWord.lane[2'd3 - bytePtr] = byte_i;
    end

    assign fullPush  = byteStb_i && (bytePtr == 2'd3);
    // Partial word goes out in a clock without a new byte
    assign flushPush = flushPend && (bytePtr != 2'd0) && !byteStb_i && !full;
    assign push      = fullPush || flushPush;
    assign pop       = pop_i && (count != '0);
    assign drained   = flushPend && (count == '0) && (bytePtr == 2'd0);

    always_ff @(posedge nSCLK or negedge nAS_) begin
        if (!nAS_) begin
            packWord  <= '0;
            bytePtr   <= '0;
            wrPtr     <= '0;
            rdPtr     <= '0;
            count     <= '0;
            flushPend <= 1'b0;
            flushDone <= 1'b0;
        end else begin
            if (push) begin
                packWord <= '0;
                bytePtr  <= '0;
                wrPtr    <= wrPtr + 1'b1;
            end else if (byteStb_i) begin
                packWord <= pushWord;
                bytePtr  <= bytePtr + 2'd1;
            end

            if (pop)
                rdPtr <= rdPtr + 1'b1;

            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            // Flush stays pending until storage and packer are both empty
            if (ctrl_i.flushReq)
                flushPend <= 1'b1;
            else if (drained)
                flushPend <= 1'b0;
            flushDone <= drained;
        end
    end

    always_ff @(posedge nSCLK) begin
        if (push)
            mem[wrPtr] <= pushWord;
    end

    assign head_o = mem[rdPtr];

    assign stat_o = '{empty:     (count == '0),
                      full:      full,
                      wordReady: (count != '0),
                      leftover:  (bytePtr != 2'd0),
                      flushDone: flushDone};

endmodule

`default_nettype wire

/* busMaster.sv */
// Bus arbitration and longword write sequencer that drains the FIFO to memory at the ACR address
`default_nettype none

module busMaster import sdmacPkg::*; (
    input  logic      nSCLK,
    input  logic      nAS_,
    input  dmaCtrl_s  ctrl_i,
    input  logic      wordReady_i,
    input  fifoWord_u head_i,
    output logic      pop_o,
    output logic      brO_,
    input  logic      bgI_,
    output logic      bgackO_,
    output logic      asO_,
    input  logic      dsackI_,
    output busCycle_s cycle_o
);

    logic [2:0]  state;
    logic [31:0] addr;  // Next write address
    logic        startCycle;
    logic        cycleDone;

    assign startCycle = (state == BM_OWN) && wordReady_i && ctrl_i.dmaEna;
    assign cycleDone  = (state == BM_STROBE) && !dsackI_;

    assign brO_    = !((state != BM_IDLE) && ctrl_i.dmaEna);
    assign bgackO_ = !((state == BM_OWN) || (state == BM_STROBE) || (state == BM_END));
    assign asO_    = (state != BM_STROBE);
    assign pop_o   = (state == BM_END);  // FIFO advances at the end of this clock

    always_ff @(posedge nSCLK or negedge nAS_) begin
        if (!nAS_) begin
            state <= BM_IDLE;
            addr  <= '0;
        end else begin
            case (state)
                BM_IDLE: begin
                    if (wordReady_i && ctrl_i.dmaEna)
                        state <= BM_REQ;
                end

                BM_REQ: begin
                    if (!ctrl_i.dmaEna)
                        state <= BM_IDLE;  // Request withdrawn
                    else if (!bgI_)
                        state <= BM_OWN;
                end

                // Keep the bus while words remain
                BM_OWN:    state <= startCycle ? BM_STROBE : BM_IDLE;
                BM_STROBE: state <= cycleDone ? BM_END : BM_STROBE;
                BM_END:    state <= BM_OWN;
                default:   state <= BM_IDLE;
            endcase

            if (ctrl_i.acrLoad)
                addr <= ctrl_i.acr;
            else if (cycleDone)
                addr <= addr + 32'd4;
        end
    end

    // Address and data stay put past the AS rising edge
    always_ff @(posedge nSCLK) begin
        if (startCycle)
            cycle_o <= '{addr: addr, data: head_i.lword};
    end

endmodule

`default_nettype wire

/* sdmacTop.sv */
// SDMAC top level joining register port, SCSI sequencer, packing FIFO and bus master to the pins
`default_nettype none

module sdmacTop import sdmacPkg::*; (
    input  logic        nSCLK,
    input  logic        nAS_,
    input  regAccess_s  regAcc_i,
    output logic [31:0] regRdata_o,
    input  logic        intA_i,
    output logic        intO_,
    input  logic        dreqI_,
    output logic        dackO_,
    output logic        iorO_,
    input  logic [7:0]  pdI,
    output logic        brO_,
    input  logic        bgI_,
    output logic        bgackO_,
    output logic        asO_,
    input  logic        dsackI_,
    output busCycle_s   cycle_o
);

    dmaCtrl_s   ctrl;
    fifoStat_s  fifoStat;
    logic       byteStb;
    logic [7:0] byteData;
    logic       pop;
    fifoWord_u  head;

    regDecode regDecode_i (
        .nSCLK      (nSCLK),
        .nAS_       (nAS_),
        .regAcc_i   (regAcc_i),
        .fifoStat_i (fifoStat),
        .intA_i     (intA_i),
        .ctrl_o     (ctrl),
        .regRdata_o (regRdata_o),
        .intO_      (intO_)
    );

    scsiXfer scsiXfer_i (
        .nSCLK      (nSCLK),
        .nAS_       (nAS_),
        .ctrl_i     (ctrl),
        .fifoFull_i (fifoStat.full),
        .dreqI_     (dreqI_),
        .pdI        (pdI),
        .dackO_     (dackO_),
        .iorO_      (iorO_),
        .byteStb_o  (byteStb),
        .byte_o     (byteData)
    );

    byteFifo byteFifo_i (
        .nSCLK     (nSCLK),
        .nAS_      (nAS_),
        .ctrl_i    (ctrl),
        .byteStb_i (byteStb),
        .byte_i    (byteData),
        .pop_i     (pop),
        .head_o    (head),
        .stat_o    (fifoStat)
    );

    busMaster busMaster_i (
        .nSCLK       (nSCLK),
        .nAS_        (nAS_),
        .ctrl_i      (ctrl),
        .wordReady_i (fifoStat.wordReady),
        .head_i      (head),
        .pop_o       (pop),
        .brO_        (brO_),
        .bgI_        (bgI_),
        .bgackO_     (bgackO_),
        .asO_        (asO_),
        .dsackI_     (dsackI_),
        .cycle_o     (cycle_o)
    );

endmodule

`default_nettype wire

/* sdmac_chk.sv */
// Protocol checks on SCSI strobes and bus handshake, bound into sdmacTop during simulation
`default_nettype none

module sdmacChk import sdmacPkg::*; (
    input logic nSCLK,
    input logic nAS_,
    input logic dack_i,
    input logic ior_i,
    input logic as_i,
    input logic bgack_i,
    input logic dsack_i,
    input logic br_i,
    input logic dmaEna_i,
    input logic wordReady_i
);

    // One strobe of IOR_CYCLES clocks on both lines
    dackIorTogether: assert property (@(posedge nSCLK) disable iff (!nAS_)
        (dack_i == ior_i) && (!$rose(dack_i)
            || ($past(!dack_i, IOR_CYCLES) && $past(dack_i, IOR_CYCLES + 1))))
        else $error("DACK and IOR strobes differ");

    // BGACK already low the clock before AS
    asNeedsBgack: assert property (@(posedge nSCLK) disable iff (!nAS_)
        !as_i |-> !bgack_i && $past(!bgack_i))
        else $error("AS low without BGACK");

    // AS may only end once DSACK has been sampled low
    asHeldForDsack: assert property (@(posedge nSCLK) disable iff (!nAS_)
        (!as_i && dsack_i) |=> !as_i)
        else $error("AS released before DSACK");

    // A new request only for a waiting word
    brNeedsDmaEna: assert property (@(posedge nSCLK) disable iff (!nAS_)
        !br_i |-> dmaEna_i && ($past(!br_i) || $past(wordReady_i)))
        else $error("Bus request with DMA disabled");

endmodule

bind sdmacTop sdmacChk chk_i (
    .nSCLK(nSCLK), .nAS_(nAS_), .dack_i(dackO_), .ior_i(iorO_), .as_i(asO_),
    .bgack_i(bgackO_), .dsack_i(dsackI_), .br_i(brO_), .dmaEna_i(ctrl.dmaEna),
    .wordReady_i(fifoStat.wordReady)
);

`default_nettype wire

/* sdmacTb.sv */
// Testbench for sdmacTop: SCSI device model, bus arbiter and memory slave, CPU register tasks
`default_nettype none

module sdmacTb import sdmacPkg::*; ;

    localparam int TIMEOUT_CYCLES = 4000;  // 64+ bytes at ~8 clocks plus bus waits, with margin

    logic        nSCLK = 1'b0;
    logic        nAS_;
    regAccess_s  regAcc;
    logic [31:0] regRdata;
    logic        intA;
    logic        intO_;
    logic        dreqI_;
    logic        dackO_;
    logic        iorO_;
    logic [7:0]  pdI;
    logic        brO_;
    logic        bgI_;
    logic        bgackO_;
    logic        asO_;
    logic        dsackI_;
    busCycle_s   cycle;

    logic [7:0]  sentBytes[$];  // Bytes taken by the DUT in the current test
    logic [31:0] baseAddr;
    logic [31:0] rd;
    logic        grantEn;
    int          wordIdx = 0;
    int          expWords = 0;
    int          takenCount = 0;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    sdmacTop dut_i (
        .nSCLK(nSCLK), .nAS_(nAS_), .regAcc_i(regAcc), .regRdata_o(regRdata),
        .intA_i(intA), .intO_(intO_), .dreqI_(dreqI_), .dackO_(dackO_), .iorO_(iorO_),
        .pdI(pdI), .brO_(brO_), .bgI_(bgI_), .bgackO_(bgackO_), .asO_(asO_),
        .dsackI_(dsackI_), .cycle_o(cycle)
    );

    always #4 nSCLK = ~nSCLK;

    // Four bytes per longword, first byte in the top lane, zeros past the end
    function automatic logic [31:0] expectedWord(input logic [7:0] bytes[$], input int idx);
        logic [31:0] w;
        int pos;
        w = '0;
        for (int k = 0; k < 4; k++) begin
            pos = 4 * idx + k;
            if (pos < bytes.size())
                w[31 - 8*k -: 8] = bytes[pos];
        end
        return w;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    task automatic regWrite(input logic [4:0] addr, input logic [31:0] data);
        @(posedge nSCLK);
        #1;
        regAcc = '{strobe: 1'b1, write: 1'b1, addr: addr, wdata: data};
        @(posedge nSCLK);
        #1;
        regAcc = '0;
    endtask

    task automatic regRead(input logic [4:0] addr, output logic [31:0] data);
        @(posedge nSCLK);
        #1;
        regAcc = '{strobe: 1'b1, write: 1'b0, addr: addr, wdata: 32'h0};
        @(posedge nSCLK);
        #1;
        regAcc = '0;
        data = regRdata;  // Registered on the strobe edge
    endtask

    task automatic waitStatus(input int bitPos);
        logic [31:0] istr;
        regRead(REG_ISTR, istr);
        while (!istr[bitPos])
            regRead(REG_ISTR, istr);
    endtask

    task automatic waitWordCount(input int n);
        while (wordIdx < n)
            @(posedge nSCLK);
        #1;
    endtask

    task automatic startCheck(input logic [31:0] base, input int nWords);
        sentBytes.delete();
        wordIdx = 0;
        takenCount = 0;
        expWords = nWords;
        baseAddr = base;
        regWrite(REG_ACR, base);
    endtask

    // SCSI device: DREQ low with the byte on the port, released once DACK is seen
    task automatic sendBytes(input int n);
        logic [7:0] b;
        int gap;
        for (int i = 0; i < n; i++) begin
            b = 8'($urandom);
            gap = $urandom_range(0, 3);
            repeat (gap) @(posedge nSCLK);
            @(posedge nSCLK);
            #1;
            pdI = b;
            dreqI_ = 1'b0;
            sentBytes.push_back(b);
            @(posedge nSCLK);
            while (dackO_)
                @(posedge nSCLK);
            #1;
            dreqI_ = 1'b1;
            while (!dackO_)
                @(posedge nSCLK);
            #1;
            takenCount++;
        end
    endtask

    // Bus grant after a random wait, withdrawn when the request goes away
    always begin : busArbiter
        @(posedge nSCLK);
        if (!brO_ && grantEn && bgI_) begin
            repeat ($urandom_range(0, 3)) @(posedge nSCLK);
            #1 bgI_ = 1'b0;
        end else if (brO_ && !bgI_) begin
            #1 bgI_ = 1'b1;
        end
    end

    always begin : memorySlave
        @(posedge nSCLK);
        if (!asO_ && dsackI_) begin
            repeat ($urandom_range(0, 3)) @(posedge nSCLK);
            #1 dsackI_ = 1'b0;
        end else if (asO_ && !dsackI_) begin
            #1 dsackI_ = 1'b1;
        end
    end

    // The edge that ends a write cycle, AS low with DSACK seen
    always @(posedge nSCLK) begin : compareWrites
        if (nAS_ && !asO_ && !dsackI_) begin
            if (wordIdx >= expWords) begin
                errors++;
                $display("A bus write appeared when no word was expected");
            end else begin
                checkValue("cycle_o.addr", cycle.addr, baseAddr + 32'(4 * wordIdx));
                checkValue("cycle_o.data", cycle.data, expectedWord(sentBytes, wordIdx));
            end
            wordIdx++;
        end
    end

    always @(posedge nSCLK) begin : watchdog
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(76));
        nAS_ = 1'b0;
        regAcc = '0;
        intA = 1'b0;
        dreqI_ = 1'b1;
        pdI = 8'h00;
        bgI_ = 1'b1;
        dsackI_ = 1'b1;
        grantEn = 1'b1;
        baseAddr = '0;
        repeat (3) @(posedge nSCLK);
        #1 nAS_ = 1'b1;

        // Register read-back
        regRead(REG_ISTR, rd);
        checkValue("ISTR", rd, 32'd1 << ISTR_FEMPTY);
        regWrite(REG_CNTR, 32'd1 << CNTR_INTENA);
        regRead(REG_CNTR, rd);
        checkValue("CNTR", rd, 32'd1 << CNTR_INTENA);
        regWrite(REG_CNTR, (32'd1 << CNTR_DMAENA) | (32'd1 << CNTR_INTENA));
        regRead(REG_CNTR, rd);
        checkValue("CNTR", rd, (32'd1 << CNTR_DMAENA) | (32'd1 << CNTR_INTENA));

        // Packing, 32 bytes into 8 longwords
        startCheck(32'h0001_0000 | (($urandom & 32'h0000_0FFF) << 4), 8);
        regRead(REG_ACR, rd);
        checkValue("ACR", rd, baseAddr);
        sendBytes(32);
        waitWordCount(8);

        // Back-pressure, grant withheld until the FIFO is full
        grantEn = 1'b0;
        startCheck(32'h0002_0000, 9);
        fork
            sendBytes(36);
            begin
                waitStatus(ISTR_FFULL);
                checkValue("bytesTaken", 32'(takenCount), 32'd32);
                repeat (16) @(posedge nSCLK);
                checkValue("bytesTaken", 32'(takenCount), 32'd32);  // Device stalled on DREQ
                #1 grantEn = 1'b1;
            end
        join
        waitWordCount(9);

        // Flush of a partial word
        startCheck(32'h0003_0000, 2);
        sendBytes(6);
        waitWordCount(1);
        repeat (2) @(posedge nSCLK);
        regWrite(REG_FLUSH, 32'h0);
        waitWordCount(2);
        waitStatus(ISTR_FLUSHDONE);
        checkValue("intO_", 32'(intO_), 32'd0);
        regWrite(REG_CINT, 32'h0);
        checkValue("intO_", 32'(intO_), 32'd1);
        regRead(REG_ISTR, rd);
        checkValue("ISTR", rd, 32'd1 << ISTR_FEMPTY);

        // Interrupt gating
        intA = 1'b1;
        regRead(REG_ISTR, rd);
        checkValue("ISTR", rd, (32'd1 << ISTR_FEMPTY) | (32'd1 << ISTR_INTA)
                               | (32'd1 << ISTR_INTPEND));
        checkValue("intO_", 32'(intO_), 32'd0);
        regWrite(REG_CNTR, 32'd1 << CNTR_DMAENA);
        checkValue("intO_", 32'(intO_), 32'd1);
        regRead(REG_ISTR, rd);
        checkValue("ISTR", rd, (32'd1 << ISTR_FEMPTY) | (32'd1 << ISTR_INTA));
        intA = 1'b0;

        // DMA disabled with a word waiting, DREQ and the word must stay unanswered
        grantEn = 1'b0;
        startCheck(32'h0004_0000, 1);
        sendBytes(4);
        regWrite(REG_CNTR, 32'd1 << CNTR_INTENA);
        grantEn = 1'b1;
        dreqI_ = 1'b0;
        pdI = 8'hA5;
        repeat (20) begin
            @(posedge nSCLK);
            checkValue("dackO_", 32'(dackO_), 32'd1);
            checkValue("iorO_", 32'(iorO_), 32'd1);
            checkValue("brO_", 32'(brO_), 32'd1);
            checkValue("bgackO_", 32'(bgackO_), 32'd1);
        end
        #1 dreqI_ = 1'b1;

        // Held word goes out once DMA is back on
        regWrite(REG_CNTR, 32'd1 << CNTR_DMAENA);
        waitWordCount(1);
        repeat (4) @(posedge nSCLK);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
sdmacPkg.sv
regDecode.sv
scsiXfer.sv
byteFifo.sv
busMaster.sv
sdmacTop.sv
sdmac_chk.sv
sdmacTb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := sdmacTb
FILELIST  := src.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := Testbench failed
PASS_MSG  := Testbench passed
SRCS      := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	@! grep -q "$(FAIL_MSG)" $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
